// ==== all.f ====
+incdir+verilog
verilog/xgmii_pkg.sv
verilog/frame_pkg.sv
verilog/rx_xgmii_decode.sv
verilog/rx_crc_check.sv
verilog/rx_axis_out.sv
verilog/mac_rx.sv
sim/tb_mac_rx.sv

// ==== sim/tb_mac_rx.sv ====
module tb_mac_rx;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned seed = 32'h8a3427a4;
    localparam int num_frames = 60;
    localparam int max_payload = 196;
    localparam int clk_half = 4;
    // Worst case words per frame, doubled for valid gaps
    localparam int frame_cycles = 2 * (max_payload / 4 + 12);
    localparam longint watchdog_ns = 2 * (num_frames * frame_cycles + 100) * 2 * clk_half;

    localparam int kind_good = 0;
    localparam int kind_bad_fcs = 1;
    localparam int kind_runt = 2;
    localparam int kind_err_char = 3;
    localparam int kind_stray_ctl = 4;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  keep;
        logic        last;
        logic        user;
    } exp_beat_t;

    logic        rx_clk;
    logic        rx_reset;
    logic [31:0] xgmii_rx_data;
    logic [3:0]  xgmii_rx_ctl;
    logic        phy_rx_valid;
    logic [3:0]  term_loc;
    logic [31:0] m_axis_tdata;
    logic [3:0]  m_axis_tkeep;
    logic        m_axis_tvalid;
    logic        m_axis_tlast;
    logic        m_axis_tuser;
    logic [15:0] frames_ok;
    logic [15:0] frames_bad;

    exp_beat_t  exp_q[$];
    logic [7:0] frame_bytes [0:255];
    int         errors = 0;
    int         exp_ok = 0;
    int         exp_bad = 0;
    int         frames_seen = 0;

    mac_rx u_dut (
        .rx_clk        (rx_clk),
        .rx_reset      (rx_reset),
        .xgmii_rx_data (xgmii_rx_data),
        .xgmii_rx_ctl  (xgmii_rx_ctl),
        .phy_rx_valid  (phy_rx_valid),
        .term_loc      (term_loc),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .frames_ok     (frames_ok),
        .frames_bad    (frames_bad)
    );

    initial rx_clk = 1'b0;
    always #clk_half rx_clk = ~rx_clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    function automatic logic [31:0] keep_mask(input logic [3:0] keep);
        logic [31:0] m;
        m = '0;
        for (int j = 0; j < 4; j++) begin
            m[8*j +: 8] = {8{keep[j]}};
        end
        return m;
    endfunction

    // Ethernet FCS over the first len bytes, sent low byte first
    function automatic logic [31:0] fcs_of(input int len);
        logic [31:0] c;
        c = 32'hffffffff;
        for (int i = 0; i < len; i++) begin
            for (int b = 0; b < 8; b++) begin
                if (c[0] ^ frame_bytes[i][b]) begin
                    c = (c >> 1) ^ 32'hedb88320;
                end else begin
                    c = c >> 1;
                end
            end
        end
        return ~c;
    endfunction

    // One accepted word, sometimes preceded by a dead cycle with garbage
    task automatic drive_word(input logic [31:0] data, input logic [3:0] ctl,
                              input logic [3:0] term);
        if ($urandom_range(7) == 0) begin
            phy_rx_valid  = 1'b0;
            xgmii_rx_data = $urandom;
            xgmii_rx_ctl  = $urandom;
            term_loc      = $urandom;
            @(negedge rx_clk);
        end
        phy_rx_valid  = 1'b1;
        xgmii_rx_data = data;
        xgmii_rx_ctl  = ctl;
        term_loc      = term;
        @(negedge rx_clk);
    endtask

    task automatic queue_beats(input int n, input logic bad);
        exp_beat_t b;
        int        nbeats;
        nbeats = (n + 3) / 4;
        for (int w = 0; w < nbeats; w++) begin
            b = '0;
            for (int j = 0; j < 4; j++) begin
                if (4 * w + j < n) begin
                    b.data[8*j +: 8] = frame_bytes[4*w + j];
                    b.keep[j]        = 1'b1;
                end
            end
            b.last = (w == nbeats - 1);
            b.user = b.last && bad;
            exp_q.push_back(b);
        end
        if (bad) begin
            exp_bad++;
        end else begin
            exp_ok++;
        end
    endtask

    task automatic send_frame(input int kind);
        int          len;
        int          n;
        int          err_idx;
        int          idx;
        logic [31:0] fcs;
        logic [31:0] data;
        logic [3:0]  ctl;
        logic [3:0]  term;
        len = (kind == kind_runt) ? $urandom_range(59, 8) : $urandom_range(max_payload, 60);
        n   = len + 4;
        for (int i = 0; i < len; i++) begin
            frame_bytes[i] = $urandom;
        end
        err_idx = -1;
        if (kind == kind_err_char || kind == kind_stray_ctl) begin
            // Inside the payload and covered by the FCS, only the ctl flag marks it
            err_idx = $urandom_range(len - 1);
            frame_bytes[err_idx] = (kind == kind_err_char) ? 8'hfe : 8'h1c;
        end
        fcs = fcs_of(len);
        for (int i = 0; i < 4; i++) begin
            frame_bytes[len + i] = fcs[8*i +: 8];
        end
        if (kind == kind_bad_fcs) begin
            frame_bytes[len + $urandom_range(3)] ^= 8'($urandom_range(255, 1));
        end
        queue_beats(n, kind != kind_good);
        drive_word(32'h555555fb, 4'b0001, 4'b0000);
        drive_word(32'hd5555555, 4'b0000, 4'b0000);
        // Terminate lane follows from n mod 4
        for (int w = 0; w <= n / 4; w++) begin
            data = '0;
            ctl  = '0;
            term = '0;
            for (int j = 0; j < 4; j++) begin
                idx = 4 * w + j;
                if (idx < n) begin
                    data[8*j +: 8] = frame_bytes[idx];
                    ctl[j]         = (idx == err_idx);
                end else if (idx == n) begin
                    data[8*j +: 8] = 8'hfd;
                    ctl[j]         = 1'b1;
                    term[j]        = 1'b1;
                end else begin
                    data[8*j +: 8] = 8'h07;
                    ctl[j]         = 1'b1;
                end
            end
            drive_word(data, ctl, term);
        end
        repeat ($urandom_range(4, 1)) drive_word(32'h07070707, 4'hf, 4'h0);
    endtask

    always @(negedge rx_clk) begin
        exp_beat_t   e;
        logic [31:0] mask;
        if (!rx_reset && m_axis_tvalid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("output beat arrived while no beat was expected");
            end else begin
                e    = exp_q.pop_front();
                mask = keep_mask(e.keep);
                check_value($sformatf("frame %0d tdata", frames_seen),
                            e.data & mask, m_axis_tdata & mask);
                check_value($sformatf("frame %0d tkeep", frames_seen), e.keep, m_axis_tkeep);
                check_value($sformatf("frame %0d tlast", frames_seen), e.last, m_axis_tlast);
                check_value($sformatf("frame %0d tuser", frames_seen), e.user, m_axis_tuser);
                if (e.last) begin
                    frames_seen++;
                end
            end
        end
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before the run completed");
        $display("Something failed");
        $finish;
    end

    initial begin
        void'($urandom(seed));
        rx_reset      = 1'b1;
        phy_rx_valid  = 1'b0;
        xgmii_rx_data = 32'h07070707;
        xgmii_rx_ctl  = 4'hf;
        term_loc      = 4'h0;
        repeat (4) @(posedge rx_clk);
        @(negedge rx_clk);
        rx_reset = 1'b0;

        check_value("reset tvalid", 0, m_axis_tvalid);
        check_value("reset tlast", 0, m_axis_tlast);
        check_value("reset tuser", 0, m_axis_tuser);
        check_value("reset tdata", 0, m_axis_tdata);
        check_value("reset frames_ok", 0, frames_ok);
        check_value("reset frames_bad", 0, frames_bad);

        // Every kind once up front, then a mix weighted towards good frames
        for (int f = 0; f < num_frames; f++) begin
            if (f < 5) begin
                send_frame(f);
            end else begin
                send_frame(($urandom_range(9) < 5) ? kind_good : $urandom_range(4, 1));
            end
        end

        for (int i = 0; i < 40 && exp_q.size() > 0; i++) begin
            drive_word(32'h07070707, 4'hf, 4'h0);
        end
        repeat (4) drive_word(32'h07070707, 4'hf, 4'h0);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected beats never appeared on the output", exp_q.size());
        end
        check_value("frames_ok", exp_ok, frames_ok);
        check_value("frames_bad", exp_bad, frames_bad);

        $display("errors %0d, frames ok %0d, frames bad %0d", errors, exp_ok, exp_bad);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verilog/mac_rx.sv ====
`include "mac_rx_consts.svh"

module mac_rx
    import xgmii_pkg::*, frame_pkg::*;
(
    input  logic                    rx_clk,
    input  logic                    rx_reset,
    input  logic [`DATA_WIDTH-1:0]  xgmii_rx_data,
    input  logic [`DATA_NBYTES-1:0] xgmii_rx_ctl,
    input  logic                    phy_rx_valid,
    input  logic [`DATA_NBYTES-1:0] term_loc,
    output logic [`DATA_WIDTH-1:0]  m_axis_tdata,
    output logic [`DATA_NBYTES-1:0] m_axis_tkeep,
    output logic                    m_axis_tvalid,
    output logic                    m_axis_tlast,
    output logic                    m_axis_tuser,
    output logic [`CNT_WIDTH-1:0]   frames_ok,
    output logic [`CNT_WIDTH-1:0]   frames_bad
);

    xgmii_word_t  rx_word;
    frame_beat_t  dec_beat;
    logic         dec_valid;
    logic         dec_code_err;
    frame_beat_t  crc_beat;
    logic         crc_valid;
    beat_status_t crc_status;

    assign rx_word.data = xgmii_rx_data;
    assign rx_word.ctl  = xgmii_rx_ctl;

    rx_xgmii_decode u_decode (
        .rx_clk       (rx_clk),
        .rx_reset     (rx_reset),
        .word         (rx_word),
        .phy_rx_valid (phy_rx_valid),
        .term_loc     (term_loc),
        .beat         (dec_beat),
        .beat_valid   (dec_valid),
        .code_err     (dec_code_err)
    );

    rx_crc_check u_crc (
        .rx_clk     (rx_clk),
        .rx_reset   (rx_reset),
        .beat_in    (dec_beat),
        .valid_in   (dec_valid),
        .code_err   (dec_code_err),
        .beat       (crc_beat),
        .beat_valid (crc_valid),
        .status     (crc_status)
    );

    rx_axis_out u_out (
        .rx_clk        (rx_clk),
        .rx_reset      (rx_reset),
        .beat_in       (crc_beat),
        .valid_in      (crc_valid),
        .status        (crc_status),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tuser  (m_axis_tuser),
        .frames_ok     (frames_ok),
        .frames_bad    (frames_bad)
    );

endmodule

// ==== verilog/rx_axis_out.sv ====
`include "mac_rx_consts.svh"

module rx_axis_out
    import frame_pkg::*;
(
    input  logic                    rx_clk,
    input  logic                    rx_reset,
    input  frame_beat_t             beat_in,
    input  logic                    valid_in,
    input  beat_status_t            status,
    output logic [`DATA_WIDTH-1:0]  m_axis_tdata,
    output logic [`DATA_NBYTES-1:0] m_axis_tkeep,
    output logic                    m_axis_tvalid,
    output logic                    m_axis_tlast,
    output logic                    m_axis_tuser,
    output logic [`CNT_WIDTH-1:0]   frames_ok,
    output logic [`CNT_WIDTH-1:0]   frames_bad
);

    logic frame_end;
    logic frame_bad;

    always_comb begin
        frame_end = valid_in && beat_in.last;
        frame_bad = |status;
    end

    always_ff @(posedge rx_clk) begin
        if (rx_reset) begin
            m_axis_tdata  <= '0;
            m_axis_tkeep  <= '0;
            m_axis_tvalid <= 1'b0;
            m_axis_tlast  <= 1'b0;
            m_axis_tuser  <= 1'b0;
            frames_ok     <= '0;
            frames_bad    <= '0;
        end else begin
            m_axis_tvalid <= valid_in;
            m_axis_tlast  <= frame_end;
            m_axis_tuser  <= frame_end && frame_bad;
            if (valid_in) begin
                m_axis_tdata <= beat_in.data;
                m_axis_tkeep <= beat_in.keep;
            end
            // One count per frame
            if (frame_end) begin
                if (frame_bad) begin
                    frames_bad <= frames_bad + 1'b1;
                end else begin
                    frames_ok <= frames_ok + 1'b1;
                end
            end
        end
    end

endmodule

// ==== verilog/rx_crc_check.sv ====
`include "mac_rx_consts.svh"

module rx_crc_check
    import frame_pkg::*;
(
    input  logic         rx_clk,
    input  logic         rx_reset,
    input  frame_beat_t  beat_in,
    input  logic         valid_in,
    input  logic         code_err,
    output frame_beat_t  beat,
    output logic         beat_valid,
    output beat_status_t status
);

    localparam int byte_cnt_w = 16;

    logic [31:0]           crc;
    logic [31:0]           crc_next;
    logic [byte_cnt_w-1:0] byte_cnt;
    logic [byte_cnt_w-1:0] cnt_next;
    logic                  err_sticky;
    beat_status_t          frame_status;

    // One byte through the reflected CRC, LSB first
    function automatic logic [31:0] crc_byte(
        input logic [31:0] crc_in,
        input logic [7:0]  data
    );
        logic [31:0] c;
        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ `CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_comb begin
        crc_next = crc;
        cnt_next = byte_cnt;
        for (int i = 0; i < `DATA_NBYTES; i++) begin
            if (beat_in.keep[i]) begin
                crc_next = crc_byte(crc_next, beat_in.data[8*i +: 8]);
                // Saturate so a long frame never reads as a runt
                if (cnt_next != '1) begin
                    cnt_next = cnt_next + 1'b1;
                end
            end
        end
        frame_status.code_err = err_sticky | code_err;
        frame_status.crc_err  = (crc_next != `CRC_RESIDUE);
        frame_status.runt     = (cnt_next < `MIN_FRAME_BYTES);
    end

    always_ff @(posedge rx_clk) begin
        if (rx_reset) begin
            crc        <= `CRC_INIT;
            byte_cnt   <= '0;
            err_sticky <= 1'b0;
            beat_valid <= 1'b0;
            status     <= '0;
        end else begin
            beat_valid <= valid_in;
            if (valid_in) begin
                beat <= beat_in;
                if (beat_in.last) begin
                    status     <= frame_status;
                    crc        <= `CRC_INIT;
                    byte_cnt   <= '0;
                    err_sticky <= 1'b0;
                end else begin
                    status     <= '0;
                    crc        <= crc_next;
                    byte_cnt   <= cnt_next;
                    err_sticky <= err_sticky | code_err;
                end
            end
        end
    end

endmodule

// ==== verilog/rx_xgmii_decode.sv ====
`include "mac_rx_consts.svh"

module rx_xgmii_decode
    import xgmii_pkg::*, frame_pkg::*;
(
    input  logic                    rx_clk,
    input  logic                    rx_reset,
    input  xgmii_word_t             word,
    input  logic                    phy_rx_valid,
    input  logic [`DATA_NBYTES-1:0] term_loc,
    output frame_beat_t             beat,
    output logic                    beat_valid,
    output logic                    code_err
);

    rx_state_e state;

    logic [`DATA_WIDTH-1:0] held_data;
    logic                   held_valid;
    frame_beat_t            tail;
    logic                   tail_pending;
    logic                   frame_err;

    logic                    is_start;
    logic                    is_idle;
    logic                    has_term;
    logic [`DATA_NBYTES-1:0] low_mask;
    logic                    word_err;

    always_comb begin
        is_start = word.ctl[0] && (word.data[0] == char_start);
        is_idle  = word.ctl[0] && (word.data[0] == char_idle);
        has_term = |term_loc;
        // Lanes ahead of the terminate still carry frame bytes
        low_mask = has_term ? term_loc - 1'b1 : {`DATA_NBYTES{1'b1}};
        word_err = |(word.ctl & low_mask);
        for (int i = 0; i < `DATA_NBYTES; i++) begin
            if (word.ctl[i] && (word.data[i] == char_error)) begin
                word_err = 1'b1;
            end
            if (term_loc[i] && (!word.ctl[i] || (word.data[i] != char_term))) begin
                word_err = 1'b1;
            end
        end
    end

    always_ff @(posedge rx_clk) begin
        if (rx_reset) begin
            state        <= st_idle;
            held_valid   <= 1'b0;
            tail_pending <= 1'b0;
            frame_err    <= 1'b0;
            beat_valid   <= 1'b0;
            code_err     <= 1'b0;
        end else begin
            beat_valid   <= 1'b0;
            tail_pending <= 1'b0;

            // Partial word left over from a terminate in lane 1..3
            if (tail_pending) begin
                beat       <= tail;
                beat_valid <= 1'b1;
                code_err   <= frame_err;
            end

            if (phy_rx_valid) begin
                case (state)
                    st_idle: begin
                        if (is_start) begin
                            state     <= st_preamble;
                            frame_err <= 1'b0;
                        end
                    end
                    st_preamble: begin
                        held_valid <= 1'b0;
                        if (word.ctl == '0 && word.data == sfd_word) begin
                            state <= st_payload;
                        end else begin
                            state <= st_drop;
                        end
                    end
                    st_payload: begin
                        if (is_start) begin
                            // Frame cut short by a new start
                            if (held_valid) begin
                                beat       <= '{data: held_data, keep: '1, last: 1'b1};
                                beat_valid <= 1'b1;
                                code_err   <= 1'b1;
                            end
                            held_valid <= 1'b0;
                            frame_err  <= 1'b0;
                            state      <= st_preamble;
                        end else if (has_term) begin
                            if (held_valid) begin
                                beat       <= '{data: held_data, keep: '1, last: term_loc[0]};
                                beat_valid <= 1'b1;
                                code_err   <= frame_err | word_err;
                            end
                            if (!term_loc[0]) begin
                                tail         <= '{data: word.data, keep: low_mask, last: 1'b1};
                                tail_pending <= 1'b1;
                            end
                            frame_err  <= frame_err | word_err;
                            held_valid <= 1'b0;
                            state      <= st_idle;
                        end else begin
                            if (held_valid) begin
                                beat       <= '{data: held_data, keep: '1, last: 1'b0};
                                beat_valid <= 1'b1;
                                code_err   <= frame_err | word_err;
                            end
                            held_data  <= word.data;
                            held_valid <= 1'b1;
                            frame_err  <= frame_err | word_err;
                        end
                    end
                    st_drop: begin
                        if (is_start) begin
                            state     <= st_preamble;
                            frame_err <= 1'b0;
                        end else if (is_idle || has_term) begin
                            state <= st_idle;
                        end
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

endmodule

// ==== verilog/frame_pkg.sv ====
`include "mac_rx_consts.svh"

package frame_pkg;

    // One beat of frame bytes, FCS included
    typedef struct packed {
        logic [`DATA_WIDTH-1:0]  data;
        logic [`DATA_NBYTES-1:0] keep;
        logic                    last;
    } frame_beat_t;

    // Frame verdict, meaningful on the last beat
    typedef struct packed {
        logic code_err;
        logic crc_err;
        logic runt;
    } beat_status_t;

    typedef enum logic [1:0] {
        st_idle,
        st_preamble,
        st_payload,
        st_drop
    } rx_state_e;

endpackage

// ==== verilog/xgmii_pkg.sv ====
`include "mac_rx_consts.svh"

package xgmii_pkg;

    // XGMII control characters, valid only with the lane's ctl bit set
    typedef enum logic [7:0] {
        char_idle  = 8'h07,
        char_start = 8'hfb,
        char_term  = 8'hfd,
        char_error = 8'hfe
    } xgmii_char_e;

    // Preamble tail and SFD, lane 0 in the low byte
    localparam logic [`DATA_WIDTH-1:0] sfd_word = 32'hd5555555;

    // One received word, lane 0 is the first byte on the wire
    typedef struct packed {
        logic [`DATA_NBYTES-1:0][7:0] data;
        logic [`DATA_NBYTES-1:0]      ctl;
    } xgmii_word_t;

endpackage

// ==== verilog/mac_rx_consts.svh ====
`ifndef MAC_RX_CONSTS_SVH
`define MAC_RX_CONSTS_SVH

// XGMII datapath
`define DATA_WIDTH 32
`define DATA_NBYTES 4

// Reflected Ethernet CRC-32
`define CRC_POLY 32'hedb88320
`define CRC_INIT 32'hffffffff

// Register value after a good frame, FCS included
`define CRC_RESIDUE 32'hdebb20e3

// Shortest legal frame, FCS included
`define MIN_FRAME_BYTES 64

`define CNT_WIDTH 16

`endif
